//--- Makefile
# Verilator simulation of the clock control testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_clock_ctrl
	./obj_dir/Vtb_clock_ctrl | tee sim.log
	@grep -q "TB PASSED" sim.log
	@! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- clock_activity_monitor.sv
`timescale 1ns/1ps

module clock_activity_monitor (
  input  logic                               clock,
  input  logic                               reset,
  input  logic [clock_ctrl_pkg::NUM_MON-1:0] mon_clock_in,  // Auxiliary clock inputs
  output logic [clock_ctrl_pkg::NUM_MON-1:0] mon_lock       // 1 while input toggles
);

  // ------------------------------------------------------------
  // Dual-edge samplers
  // ------------------------------------------------------------
  logic [clock_ctrl_pkg::NUM_MON-1:0] rise_q;  // Sampled on rising edge
  logic [clock_ctrl_pkg::NUM_MON-1:0] fall_q;  // Sampled on falling edge

  always_ff @(posedge clock) begin
    if (reset) begin
      rise_q <= '0;
    end else begin
      rise_q <= mon_clock_in;
    end
  end

  always_ff @(negedge clock) begin
    if (reset) begin
      fall_q <= '0;
    end else begin
      fall_q <= mon_clock_in;
    end
  end

  // ------------------------------------------------------------
  // Pseudo-lock status
  // ------------------------------------------------------------
  // A same-frequency clock offset from clock lands opposite values
  // in the two samplers, so the pair adds to 1
  assign mon_lock = rise_q ^ fall_q;  // Stuck input gives 0

endmodule

//--- clock_ctrl.sv
`timescale 1ns/1ps

module clock_ctrl (
  input  logic clock,
  input  logic reset,
  input  logic lock_main,        // Main PLL lock
  input  logic global_reset_en,  // Re-fire global reset on lock loss

  input  logic [clock_ctrl_pkg::NUM_MON-1:0] mon_clock_in,  // Auxiliary clocks

  input  logic [clock_ctrl_pkg::NUM_DPS-1:0] dps_fire,      // Set new phase
  input  logic [clock_ctrl_pkg::NUM_DPS-1:0] dps_reset,     // Reset channel phase
  input  logic [clock_ctrl_pkg::NUM_DPS*clock_ctrl_pkg::PHASE_IN_W-1:0] dps_phase,
  input  logic [clock_ctrl_pkg::NUM_DPS-1:0] dps_psdone,    // From channel PLLs
  input  logic [clock_ctrl_pkg::NUM_DPS-1:0] dps_pll_lock,  // From channel PLLs

  output logic global_reset,         // Held until main PLL locks
  output logic clock_lock_lost_err,  // Main lock missing while running

  output logic [clock_ctrl_pkg::NUM_MON-1:0] mon_lock,      // Pseudo-lock status

  output logic [clock_ctrl_pkg::NUM_DPS-1:0] dps_busy,      // Channel moving
  output logic [clock_ctrl_pkg::NUM_DPS*clock_ctrl_pkg::SM_W-1:0] dps_sm_vec,
  output logic [clock_ctrl_pkg::NUM_DPS-1:0] dps_psen,      // To channel PLLs
  output logic [clock_ctrl_pkg::NUM_DPS-1:0] dps_psincdec,  // To channel PLLs
  output logic [clock_ctrl_pkg::NUM_DPS-1:0] dps_pll_reset  // To channel PLLs
);

  // ------------------------------------------------------------
  // Global reset and activity monitor
  // ------------------------------------------------------------
  reset_sequencer u_reset_sequencer (
    .clock               (clock),
    .reset               (reset),
    .lock_main           (lock_main),
    .global_reset_en     (global_reset_en),
    .global_reset        (global_reset),
    .clock_lock_lost_err (clock_lock_lost_err)
  );

  clock_activity_monitor u_activity_monitor (
    .clock        (clock),
    .reset        (reset),
    .mon_clock_in (mon_clock_in),
    .mon_lock     (mon_lock)
  );

  // ------------------------------------------------------------
  // Phase shifter channels
  // ------------------------------------------------------------
  for (genvar i = 0; i < clock_ctrl_pkg::NUM_DPS; i++) begin : g_dps
    logic                              start;        // Register bank to phaser
    logic [clock_ctrl_pkg::STEP_W-1:0] target_step;  // Translated target

    dps_pll_if u_pll ();

    // Board side of the PLL port
    assign u_pll.psdone = dps_psdone[i];
    assign u_pll.lock   = dps_pll_lock[i];
    assign dps_psen[i]      = u_pll.psen;
    assign dps_psincdec[i]  = u_pll.psincdec;
    assign dps_pll_reset[i] = u_pll.pll_reset;

    dps_phase_regs u_phase_regs (
      .clock       (clock),
      .reset       (reset),
      .fire        (dps_fire[i]),
      .phase       (dps_phase[i*clock_ctrl_pkg::PHASE_IN_W +: clock_ctrl_pkg::PHASE_IN_W]),
      .busy        (dps_busy[i]),
      .start       (start),
      .target_step (target_step)
    );

    dps_phaser u_phaser (
      .clock        (clock),
      .global_reset (global_reset),
      .lock_main    (lock_main),
      .dps_reset    (dps_reset[i]),
      .start        (start),
      .target_step  (target_step),
      .busy         (dps_busy[i]),
      .sm_vec       (dps_sm_vec[i*clock_ctrl_pkg::SM_W +: clock_ctrl_pkg::SM_W]),
      .pll          (u_pll.phaser)
    );
  end

endmodule

//--- clock_ctrl_pkg.sv
package clock_ctrl_pkg;

  // ------------------------------------------------------------
  // Channel and input counts
  // ------------------------------------------------------------
  localparam int NUM_DPS = 4;           // Digital phase shifter channels
  localparam int NUM_MON = 7;           // Auxiliary clocks under pseudo-lock watch

  // ------------------------------------------------------------
  // Phase setting and step widths
  // ------------------------------------------------------------
  localparam int PHASE_IN_W      = 8;     // Phase setting 0-255
  localparam int STEP_W          = 11;    // Step target or position 0-1399
  localparam int STEPS_PER_CYCLE = 1400;  // Fine PLL steps across one 25 ns period
  localparam int PROD_W          = PHASE_IN_W + STEP_W;  // Holds p*1400 plus rounding

  // ------------------------------------------------------------
  // Phaser state codes
  // ------------------------------------------------------------
  localparam int SM_W = 3;              // State code width, also on sm_vec

  localparam logic [SM_W-1:0] DPS_IDLE      = 3'd0;  // Parked at target
  localparam logic [SM_W-1:0] DPS_WAIT_LOCK = 3'd1;  // PLL in reset or not locked
  localparam logic [SM_W-1:0] DPS_CHECK     = 3'd2;  // Compare position to target
  localparam logic [SM_W-1:0] DPS_STEP      = 3'd3;  // Issue one psen
  localparam logic [SM_W-1:0] DPS_WAIT_DONE = 3'd4;  // Hold until psdone

endpackage

//--- dps_phase_regs.sv
`timescale 1ns/1ps

module dps_phase_regs (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  fire,         // Request a new phase
  input  logic [clock_ctrl_pkg::PHASE_IN_W-1:0] phase,        // Setting 0-255
  input  logic                                  busy,         // Phaser is moving
  output logic                                  start,        // One-cycle go to phaser
  output logic [clock_ctrl_pkg::STEP_W-1:0]     target_step   // Held target 0-1399
);

  // ------------------------------------------------------------
  // 256-to-1400 translation
  // ------------------------------------------------------------
  // Target is (p*1400 + 128) / 256, rounded to nearest step
  logic [clock_ctrl_pkg::PROD_W-1:0] phase_ext;   // Phase widened to product size
  logic [clock_ctrl_pkg::PROD_W-1:0] step_scale;  // 1400 at product size
  logic [clock_ctrl_pkg::PROD_W-1:0] round_half;  // Half of one 1/256 unit
  logic [clock_ctrl_pkg::PROD_W-1:0] scaled;      // p*1400 + 128
  logic [clock_ctrl_pkg::STEP_W-1:0] target_next; // Translated step

  assign phase_ext  = (clock_ctrl_pkg::PROD_W)'(phase);
  assign step_scale = (clock_ctrl_pkg::PROD_W)'(clock_ctrl_pkg::STEPS_PER_CYCLE);
  assign round_half = (clock_ctrl_pkg::PROD_W)'(1) << (clock_ctrl_pkg::PHASE_IN_W - 1);

  assign scaled = phase_ext * step_scale + round_half;

  // Divide by 256 is a plain shift
  assign target_next = scaled[clock_ctrl_pkg::PROD_W-1:clock_ctrl_pkg::PHASE_IN_W];

  // ------------------------------------------------------------
  // Fire acceptance
  // ------------------------------------------------------------
  // Free means not moving and no start already on its way
  logic accept;  // Fire taken this cycle

  assign accept = fire && !busy && !start;

  always_ff @(posedge clock) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= accept;  // Pulses for the cycle after the fire edge
    end
  end

  // Target only moves on an accepted fire
  always_ff @(posedge clock) begin
    if (accept) begin
      target_step <= target_next;  // Stable for the whole move
    end
  end

endmodule

//--- dps_phaser.sv
`timescale 1ns/1ps

module dps_phaser (
  input  logic                              clock,
  input  logic                              global_reset,  // Sync reset from sequencer
  input  logic                              lock_main,     // Main PLL lock
  input  logic                              dps_reset,     // Channel reset request
  input  logic                              start,         // Go, from phase registers
  input  logic [clock_ctrl_pkg::STEP_W-1:0] target_step,   // Step target 0-1399
  output logic                              busy,          // Moving toward target
  output logic [clock_ctrl_pkg::SM_W-1:0]   sm_vec,        // Current state code
  dps_pll_if.phaser                         pll            // PLL phase shift port
);

  // ------------------------------------------------------------
  // PLL reset request
  // ------------------------------------------------------------
  logic pll_hold;  // Channel reset or main lock gone

  assign pll_hold      = dps_reset || !lock_main;
  assign pll.pll_reset = pll_hold;  // Straight to the PLL

  // ------------------------------------------------------------
  // State and position registers
  // ------------------------------------------------------------
  logic [clock_ctrl_pkg::SM_W-1:0]   state;     // Phaser FSM state
  logic [clock_ctrl_pkg::STEP_W-1:0] position;  // Steps applied since PLL reset
  logic                              step_up;   // Direction of the step in flight
  logic                              at_target; // Position reached
  logic                              go_up;     // Target lies above position

  assign at_target = (position == target_step);
  assign go_up     = (target_step > position);

  always_ff @(posedge clock) begin
    if (global_reset) begin
      state    <= clock_ctrl_pkg::DPS_WAIT_LOCK;
      position <= '0;
      step_up  <= 1'b0;
    end else if (pll_hold) begin
      state    <= clock_ctrl_pkg::DPS_WAIT_LOCK;  // Parked while PLL is held
      position <= '0;                             // PLL restarts at zero shift
    end else begin
      case (state)
        clock_ctrl_pkg::DPS_WAIT_LOCK: begin
          if (pll.lock) begin
            state <= clock_ctrl_pkg::DPS_IDLE;  // PLL back up
          end
        end

        clock_ctrl_pkg::DPS_IDLE: begin
          if (start) begin
            state <= clock_ctrl_pkg::DPS_CHECK;  // busy rises here
          end
        end

        clock_ctrl_pkg::DPS_CHECK: begin
          if (at_target) begin
            state <= clock_ctrl_pkg::DPS_IDLE;  // Done, busy falls
          end else begin
            state   <= clock_ctrl_pkg::DPS_STEP;
            step_up <= go_up;                   // Latch direction for this step
          end
        end

        clock_ctrl_pkg::DPS_STEP: begin
          state <= clock_ctrl_pkg::DPS_WAIT_DONE;  // psen was high for one cycle
        end

        clock_ctrl_pkg::DPS_WAIT_DONE: begin
          if (pll.psdone) begin
            state <= clock_ctrl_pkg::DPS_CHECK;
            if (step_up) begin
              position <= position + 1'b1;
            end else begin
              position <= position - 1'b1;
            end
          end
        end

        default: begin
          state <= clock_ctrl_pkg::DPS_WAIT_LOCK;  // Unused codes recover
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------
  // psen only in STEP, so a second request waits for psdone
  assign pll.psen     = (state == clock_ctrl_pkg::DPS_STEP);
  assign pll.psincdec = step_up;  // Valid with psen

  assign busy = (state == clock_ctrl_pkg::DPS_CHECK) ||
                (state == clock_ctrl_pkg::DPS_STEP)  ||
                (state == clock_ctrl_pkg::DPS_WAIT_DONE);

  assign sm_vec = state;  // Status readback

endmodule

//--- dps_pll_if.sv
`timescale 1ns/1ps

// One channel's PLL fine phase shift port plus its lock and reset
interface dps_pll_if;

  logic psen;       // One-cycle shift request
  logic psincdec;   // 1 increments, 0 decrements
  logic pll_reset;  // Holds the PLL in reset
  logic psdone;     // One-cycle shift complete
  logic lock;       // PLL locked

  // Phaser side, drives the request lines
  modport phaser (
    output psen,
    output psincdec,
    output pll_reset,
    input  psdone,
    input  lock
  );

  // Board side, answers with psdone and lock
  modport port (
    input  psen,
    input  psincdec,
    input  pll_reset,
    output psdone,
    output lock
  );

endinterface

//--- list.f
clock_ctrl_pkg.sv
dps_pll_if.sv
reset_sequencer.sv
clock_activity_monitor.sv
dps_phase_regs.sv
dps_phaser.sv
clock_ctrl.sv
tb_pll_model.sv
tb_clock_ctrl.sv

//--- reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
  input  logic clock,
  input  logic reset,
  input  logic lock_main,            // Main PLL lock
  input  logic global_reset_en,      // Re-fire global reset on lock loss
  output logic global_reset,         // Held until main PLL locks
  output logic clock_lock_lost_err   // Main lock missing while running
);

  // ------------------------------------------------------------
  // Startup flag and global reset
  // ------------------------------------------------------------
  logic startup_done;  // Set on first lock, stays set
  logic first_lock;    // Lock now or seen before

  assign first_lock = lock_main || startup_done;

  always_ff @(posedge clock) begin
    if (reset) begin
      startup_done <= 1'b0;
      global_reset <= 1'b1;  // Design starts held
    end else begin
      startup_done <= first_lock;                                   // Latches on 1st lock
      global_reset <= !first_lock || (!lock_main && global_reset_en);  // Re-fires on loss
    end
  end

  // ------------------------------------------------------------
  // Lock-lost error
  // ------------------------------------------------------------
  // Only meaningful once out of reset, so a lock loss with re-fire
  // disabled shows here instead of in global_reset
  assign clock_lock_lost_err = !global_reset && !lock_main;

endmodule

//--- tb_clock_ctrl.sv
`timescale 1ns/1ps

module tb_clock_ctrl;

  logic                                                          clock;
  logic                                                          reset;
  logic                                                          lock_main;
  logic                                                          global_reset_en;
  logic [clock_ctrl_pkg::NUM_MON-1:0]                            mon_clock_in;
  logic [clock_ctrl_pkg::NUM_DPS-1:0]                            dps_fire;
  logic [clock_ctrl_pkg::NUM_DPS-1:0]                            dps_reset;
  logic [clock_ctrl_pkg::NUM_DPS*clock_ctrl_pkg::PHASE_IN_W-1:0] dps_phase;
  logic [clock_ctrl_pkg::NUM_DPS-1:0]                            dps_psdone;
  logic [clock_ctrl_pkg::NUM_DPS-1:0]                            dps_pll_lock;
  logic                                                          global_reset;
  logic                                                          clock_lock_lost_err;
  logic [clock_ctrl_pkg::NUM_MON-1:0]                            mon_lock;
  logic [clock_ctrl_pkg::NUM_DPS-1:0]                            dps_busy;
  logic [clock_ctrl_pkg::NUM_DPS*clock_ctrl_pkg::SM_W-1:0]       dps_sm_vec;
  logic [clock_ctrl_pkg::NUM_DPS-1:0]                            dps_psen;
  logic [clock_ctrl_pkg::NUM_DPS-1:0]                            dps_psincdec;
  logic [clock_ctrl_pkg::NUM_DPS-1:0]                            dps_pll_reset;

  logic [clock_ctrl_pkg::NUM_DPS-1:0] pll_pending;     // Model has a shift in flight
  logic [clock_ctrl_pkg::NUM_DPS-1:0] want_up;         // Expected psincdec per channel
  int   net_pos   [clock_ctrl_pkg::NUM_DPS];           // Model positions
  int   exp_pos   [clock_ctrl_pkg::NUM_DPS];           // Expected positions
  int   phase_set [clock_ctrl_pkg::NUM_DPS];           // Phase to fire
  logic clock_late;                                    // Clock copy 1 ns behind
  logic [clock_ctrl_pkg::NUM_MON-1:0] run_mask = 7'b101_1011;  // Running aux inputs
  int   errors   = 0;
  int   timeouts = 0;

  clock_ctrl u_dut (.*);

  always #2 clock = ~clock;  // 4 ns period

  // Same frequency, offset, so both edge samplers disagree
  always @(clock) begin
    #1;
    clock_late = clock;
  end
  assign mon_clock_in = clock_late ? run_mask : '0;  // Stuck bits stay 0

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic void flag_error(input string msg);
    errors++;
    $display("Fail @ %0t ns: %s", $time, msg);
  endfunction

  function automatic int phase_to_steps(input int p);
    return (p * clock_ctrl_pkg::STEPS_PER_CYCLE + 128) / 256;  // Round to nearest
  endfunction

  task automatic wait_state(input int ch, input logic [clock_ctrl_pkg::SM_W-1:0] code,
                            input int limit);
    int n;
    n = 0;
    while (dps_sm_vec[ch*clock_ctrl_pkg::SM_W +: clock_ctrl_pkg::SM_W] != code && n < limit) begin
      @(posedge clock);
      n++;
    end
    if (dps_sm_vec[ch*clock_ctrl_pkg::SM_W +: clock_ctrl_pkg::SM_W] != code) begin
      timeouts++;
      $display("Timeout: channel %0d never reached state %0d", ch, code);
    end
  endtask

  task automatic wait_global_reset(input logic level, input int limit);
    int n;
    n = 0;
    while (global_reset != level && n < limit) begin
      @(posedge clock);
      n++;
    end
    if (global_reset != level) begin
      timeouts++;
      $display("Timeout: global reset never went to %0b", level);
    end
  endtask

  task automatic wait_busy(input int ch, input int limit);
    int n;
    n = 0;
    while (!dps_busy[ch] && n < limit) begin
      @(posedge clock);
      n++;
    end
    if (!dps_busy[ch]) begin
      timeouts++;
      $display("Timeout: channel %0d never went busy after its fire", ch);
    end
  endtask

  // Busy must be seen high, then low, on every channel in mask
  task automatic wait_moves(input logic [clock_ctrl_pkg::NUM_DPS-1:0] mask, input int limit);
    logic [clock_ctrl_pkg::NUM_DPS-1:0] seen;
    int n;
    seen = '0;
    n    = 0;
    while (!((seen & mask) == mask && (dps_busy & mask) == '0) && n < limit) begin
      @(posedge clock);
      seen |= dps_busy;
      n++;
    end
    if ((seen & mask) != mask || (dps_busy & mask) != '0) begin
      timeouts++;
      $display("Timeout: channels %b did not finish their phase shift", mask);
    end
  endtask

  task automatic fire(input logic [clock_ctrl_pkg::NUM_DPS-1:0] mask);
    @(posedge clock);
    for (int i = 0; i < clock_ctrl_pkg::NUM_DPS; i++) begin
      dps_phase[i*clock_ctrl_pkg::PHASE_IN_W +: clock_ctrl_pkg::PHASE_IN_W] <=
        (clock_ctrl_pkg::PHASE_IN_W)'(phase_set[i]);
    end
    dps_fire <= mask;
    @(posedge clock);
    dps_fire <= '0;  // One-cycle request
  endtask

  task automatic check_positions();
    for (int i = 0; i < clock_ctrl_pkg::NUM_DPS; i++) begin
      assert (net_pos[i] == exp_pos[i])
        else flag_error($sformatf("channel %0d at %0d, expected %0d",
                                  i, net_pos[i], exp_pos[i]));
    end
  endtask

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  a_lock_release: assert property (@(posedge clock) disable iff (reset)
    lock_main |=> !global_reset) else flag_error("global reset held with lock present");
  a_refire: assert property (@(posedge clock) disable iff (reset)
    !lock_main && global_reset_en |=> global_reset) else flag_error("global reset not re-fired");
  a_no_refire: assert property (@(posedge clock) disable iff (reset)
    !lock_main && !global_reset_en && !global_reset |=> !global_reset)
    else flag_error("global reset rose with re-fire disabled");
  a_lost_err: assert property (@(posedge clock) disable iff (reset)
    clock_lock_lost_err == (!global_reset && !lock_main)) else flag_error("lock-lost error wrong");

  for (genvar i = 0; i < clock_ctrl_pkg::NUM_DPS; i++) begin : g_pll
    tb_pll_model u_pll_model (
      .clock     (clock),
      .psen      (dps_psen[i]),
      .psincdec  (dps_psincdec[i]),
      .pll_reset (dps_pll_reset[i]),
      .psdone    (dps_psdone[i]),
      .lock      (dps_pll_lock[i]),
      .pending   (pll_pending[i]),
      .net_pos   (net_pos[i])
    );
    a_dir: assert property (@(posedge clock) disable iff (reset)
      dps_psen[i] |-> dps_psincdec[i] == want_up[i])
      else flag_error($sformatf("channel %0d stepped the wrong way", i));
    a_one_req: assert property (@(posedge clock) disable iff (reset)
      dps_psen[i] |-> !pll_pending[i])
      else flag_error($sformatf("channel %0d issued psen before psdone", i));
    a_chan_rst: assert property (@(posedge clock) disable iff (reset)
      dps_reset[i] |-> dps_pll_reset[i])
      else flag_error($sformatf("channel %0d reset did not reach PLL", i));
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    int prev;
    void'($urandom(32'h0c03_63aa));
    clock           = 1'b0;
    clock_late      = 1'b0;
    reset           = 1'b1;
    lock_main       = 1'b0;
    global_reset_en = 1'b1;
    dps_fire        = '0;
    dps_reset       = '0;
    dps_phase       = '0;
    want_up         = '1;
    repeat (16) @(posedge clock);
    reset <= 1'b0;

    // Startup, held until first lock
    repeat (10) begin
      @(posedge clock);
      assert (global_reset) else flag_error("global reset fell without lock");
    end
    lock_main <= 1'b1;
    wait_global_reset(1'b0, 20);
    for (int i = 0; i < clock_ctrl_pkg::NUM_DPS; i++) begin
      wait_state(i, clock_ctrl_pkg::DPS_IDLE, 40);
    end

    // Lock loss with re-fire enabled
    lock_main <= 1'b0;
    wait_global_reset(1'b1, 20);
    repeat (4) @(posedge clock);
    lock_main <= 1'b1;
    wait_global_reset(1'b0, 20);

    // Lock loss with re-fire disabled
    @(posedge clock);
    global_reset_en <= 1'b0;
    lock_main       <= 1'b0;
    repeat (6) begin
      @(posedge clock);
      assert (!global_reset && clock_lock_lost_err)
        else flag_error("lock loss not flagged as error alone");
    end
    lock_main       <= 1'b1;
    global_reset_en <= 1'b1;
    @(posedge clock);
    assert (!clock_lock_lost_err) else flag_error("lock-lost error stuck after lock returned");
    for (int i = 0; i < clock_ctrl_pkg::NUM_DPS; i++) begin
      wait_state(i, clock_ctrl_pkg::DPS_IDLE, 40);
    end

    // Random phases, all channels up from zero
    for (int i = 0; i < clock_ctrl_pkg::NUM_DPS; i++) begin
      phase_set[i] = 1 + int'($urandom % 32'd255);
      exp_pos[i]   = phase_to_steps(phase_set[i]);
    end
    want_up = '1;
    fire('1);
    wait_moves('1, 25000);
    check_positions();

    // Lower settings, decrements only
    for (int i = 0; i < clock_ctrl_pkg::NUM_DPS; i++) begin
      phase_set[i] = int'($urandom % 32'(phase_set[i]));
      exp_pos[i]   = phase_to_steps(phase_set[i]);
    end
    want_up = '0;
    fire('1);
    wait_moves('1, 25000);
    check_positions();

    // Second fire during a long move on channel 1 is dropped
    prev         = phase_set[1];
    phase_set[1] = (prev < 128) ? 192 + int'($urandom % 32'd64) : int'($urandom % 32'd64);
    exp_pos[1]   = phase_to_steps(phase_set[1]);
    want_up[1]   = (phase_set[1] > prev);
    fire(4'b0010);
    wait_busy(1, 10);
    phase_set[1] = prev;
    fire(4'b0010);
    assert (dps_busy[1]) else flag_error("channel 1 move ended before the second fire");
    wait_moves(4'b0010, 25000);
    check_positions();

    // Channel reset on channel 2
    @(posedge clock);
    dps_reset[2] <= 1'b1;
    wait_state(2, clock_ctrl_pkg::DPS_WAIT_LOCK, 10);
    assert (dps_pll_reset[2]) else flag_error("channel 2 PLL reset not raised");
    repeat (3) @(posedge clock);
    dps_reset[2] <= 1'b0;
    wait_state(2, clock_ctrl_pkg::DPS_IDLE, 30);
    assert (net_pos[2] == 0) else flag_error("channel 2 position not cleared");
    phase_set[2] = 1 + int'($urandom % 32'd255);
    exp_pos[2]   = phase_to_steps(phase_set[2]);
    want_up[2]   = 1'b1;
    fire(4'b0100);
    wait_moves(4'b0100, 25000);
    check_positions();

    // Activity monitor
    repeat (8) begin
      @(posedge clock);
      assert (mon_lock == run_mask)
        else flag_error($sformatf("mon_lock %b, expected %b", mon_lock, run_mask));
    end

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tb_pll_model.sv
`timescale 1ns/1ps

module tb_pll_model (
  input  logic clock,
  input  logic psen,       // Shift request from the phaser
  input  logic psincdec,   // 1 increments
  input  logic pll_reset,  // Holds the model in reset
  output logic psdone,     // One-cycle answer per psen
  output logic lock,       // Rises 5 cycles after reset release
  output logic pending,    // Shift in flight
  output int   net_pos     // Increments minus decrements
);

  int   delay_left;  // Cycles until psdone
  int   lock_count;  // Cycles since reset release
  logic dir_up;      // Direction of the shift in flight

  initial begin
    psdone  = 1'b0;
    lock    = 1'b0;
    pending = 1'b0;
    net_pos = 0;
  end

  // ------------------------------------------------------------
  // Phase shift port and lock
  // ------------------------------------------------------------
  always @(posedge clock) begin
    if (pll_reset) begin
      net_pos    <= 0;  // Phase back to zero shift
      pending    <= 1'b0;
      psdone     <= 1'b0;
      lock       <= 1'b0;
      lock_count <= 0;
    end else begin
      psdone <= 1'b0;
      if (!lock) begin
        lock_count <= lock_count + 1;
        if (lock_count == 4) begin
          lock <= 1'b1;  // Fifth cycle out of reset
        end
      end
      if (psen) begin
        pending    <= 1'b1;
        dir_up     <= psincdec;
        delay_left <= 2 + int'($urandom % 32'd8);  // 2 to 9 cycles
      end else if (pending) begin
        if (delay_left <= 1) begin
          pending <= 1'b0;
          psdone  <= 1'b1;
          net_pos <= dir_up ? net_pos + 1 : net_pos - 1;
        end else begin
          delay_left <= delay_left - 1;
        end
      end
    end
  end

endmodule
